// File: logic/cave_pkg.sv
package cave_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Menu status word from the host
  typedef logic [31:0] status_t;
  // Raw joystick word, one per player
  typedef logic [31:0] joystick_t;
  // Key event: toggle, pressed, unused, scan code
  typedef logic [10:0] ps2_event_t;
  typedef logic [7:0]  scan_code_t;
  // Aspect ratio term for the scaler
  typedef logic [11:0] aspect_t;

  // PLL reset hold time after lock loss
  localparam int PLL_RESET_CYCLES_DEFAULT = 256;

  // Key event bits
  localparam int PS2_TOGGLE  = 10;
  localparam int PS2_PRESSED = 9;

  // Joystick word bits
  localparam int JOY_RIGHT   = 0;
  localparam int JOY_LEFT    = 1;
  localparam int JOY_DOWN    = 2;
  localparam int JOY_UP      = 3;
  localparam int JOY_BTN_LSB = 4;
  localparam int JOY_START   = 8;
  localparam int JOY_COIN    = 9;
  localparam int JOY_PAUSE   = 10;

  //////////////////////////////////////////////////
  // Scan codes, set 2
  //////////////////////////////////////////////////

  localparam scan_code_t KEY_UP    = 8'h75;
  localparam scan_code_t KEY_DOWN  = 8'h72;
  localparam scan_code_t KEY_LEFT  = 8'h6b;
  localparam scan_code_t KEY_RIGHT = 8'h74;
  localparam scan_code_t KEY_CTRL  = 8'h14;
  localparam scan_code_t KEY_ALT   = 8'h11;
  localparam scan_code_t KEY_SHIFT = 8'h12;
  localparam scan_code_t KEY_SPACE = 8'h29;
  localparam scan_code_t KEY_1     = 8'h16;
  localparam scan_code_t KEY_2     = 8'h1e;
  localparam scan_code_t KEY_5     = 8'h2e;
  localparam scan_code_t KEY_6     = 8'h36;
  localparam scan_code_t KEY_A     = 8'h1c;
  localparam scan_code_t KEY_S     = 8'h1b;
  localparam scan_code_t KEY_Q     = 8'h15;
  localparam scan_code_t KEY_R     = 8'h2d;
  localparam scan_code_t KEY_F     = 8'h2b;
  localparam scan_code_t KEY_D     = 8'h23;
  localparam scan_code_t KEY_G     = 8'h34;
  localparam scan_code_t KEY_P     = 8'h4d;
  localparam scan_code_t KEY_W     = 8'h1d;

  //////////////////////////////////////////////////
  // Status word fields
  //////////////////////////////////////////////////

  localparam int ST_RESET      = 0;
  localparam int ST_ASPECT_LSB = 1;
  localparam int ST_ROTATE     = 3;
  localparam int ST_FLIP       = 4;
  localparam int ST_FX_LSB     = 5;
  localparam int ST_COMPAT     = 8;
  localparam int ST_SERVICE    = 9;
  localparam int ST_LAYER_LSB  = 10;
  localparam int ST_GAME_LSB   = 18;
  localparam int ST_OFFX_LSB   = 24;
  localparam int ST_OFFY_LSB   = 28;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  // One player's controls, 11 bits
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] buttons;
    logic       start;
    logic       coin;
    logic       pause;
  } player_t;

  // Scaler settings, 28 bits
  typedef struct packed {
    aspect_t    arx;
    aspect_t    ary;
    logic [1:0] scanline;
    logic       scandoubler;
    logic       hq2x;
  } video_opt_t;

  // Core settings, 24 bits
  // layer_enable bit 0 is sprites, bit 7 the system framebuffer
  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       rotate;
    logic       flip;
    logic       compatibility;
    logic       service;
    logic [7:0] layer_enable;
    logic [3:0] game_index;
  } core_opt_t;

endpackage

// File: logic/reset_sequencer.sv
module reset_sequencer
  import cave_pkg::*;
#(
  parameter int PLL_RESET_CYCLES = PLL_RESET_CYCLES_DEFAULT,
  parameter int SYNC_STAGES      = 2
) (
  input  logic    clk_sys,
  input  logic    RESET,
  input  logic    pll_locked,
  input  status_t status,
  input  logic    user_reset,
  output logic    rst_pll,
  output logic    rst_sys,
  output logic    rst_cpu
);

  // Counter wide enough for the load value
  localparam int CNT_W = $clog2(PLL_RESET_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PLL_RESET_CYCLES - 1);

  //////////////////////////////////////////////////
  // PLL reset stretcher
  //////////////////////////////////////////////////

  logic             locked_q;
  logic             lock_lost;
  logic [CNT_W-1:0] pll_cnt;

  // Lock seen high last edge, low now
  assign lock_lost = locked_q & ~pll_locked;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      // Start as unlocked so power-up is not a loss
      locked_q <= 1'b0;
      rst_pll  <= 1'b0;
      pll_cnt  <= '0;
    end else begin
      locked_q <= pll_locked;
      if (lock_lost) begin
        // New loss restarts the full hold time
        rst_pll <= 1'b1;
        pll_cnt <= CNT_LOAD;
      end else if (pll_cnt != '0) begin
        pll_cnt <= pll_cnt - CNT_W'(1);
      end else begin
        rst_pll <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // System and CPU reset synchronizers
  //////////////////////////////////////////////////

  logic                   sys_cause;
  logic                   cpu_cause;
  logic [SYNC_STAGES-1:0] sys_sr;
  logic [SYNC_STAGES-1:0] cpu_sr;

  assign sys_cause = RESET | ~pll_locked;
  // CPU also held by menu reset and user button
  assign cpu_cause = sys_cause | status[ST_RESET] | user_reset;

  // Assert at once, release after SYNC_STAGES edges
  always_ff @(posedge clk_sys or posedge sys_cause) begin
    if (sys_cause) begin
      sys_sr <= '1;
    end else begin
      // Shift zeros toward the output stage
      sys_sr <= sys_sr << 1;
    end
  end

  always_ff @(posedge clk_sys or posedge cpu_cause) begin
    if (cpu_cause) begin
      cpu_sr <= '1;
    end else begin
      cpu_sr <= cpu_sr << 1;
    end
  end

  assign rst_sys = sys_sr[SYNC_STAGES-1];
  assign rst_cpu = cpu_sr[SYNC_STAGES-1];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // PLL reset drops exactly the hold time after the last lock loss
  a_pll_hold : assert property (
    @(posedge clk_sys) disable iff (RESET)
    $fell(rst_pll) |-> $past(lock_lost, PLL_RESET_CYCLES + 1)
  );

endmodule

// File: logic/control_decoder.sv
module control_decoder
  import cave_pkg::*;
(
  input  logic       clk_sys,
  input  logic       RESET,
  input  ps2_event_t ps2_key,
  input  joystick_t  joystick_0,
  input  joystick_t  joystick_1,
  output player_t    player_1,
  output player_t    player_2
);

  // Held state of every mapped key
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic ctrl;
    logic alt;
    logic shift;
    logic space;
    logic k1;
    logic k2;
    logic k5;
    logic k6;
    logic a;
    logic s;
    logic q;
    logic r;
    logic f;
    logic d;
    logic g;
    logic p;
    logic w;
  } keys_t;

  //////////////////////////////////////////////////
  // Key event tracking
  //////////////////////////////////////////////////

  logic       last_toggle;
  logic       new_event;
  logic       pressed;
  scan_code_t code;
  keys_t      keys;

  // Host flips the toggle bit once per event
  assign new_event = ps2_key[PS2_TOGGLE] ^ last_toggle;
  assign pressed   = ps2_key[PS2_PRESSED];
  assign code      = ps2_key[7:0];

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      last_toggle <= 1'b0;
      keys        <= '0;
    end else begin
      last_toggle <= ps2_key[PS2_TOGGLE];
      if (new_event) begin
        // Unmapped codes fall through untouched
        case (code)
          KEY_UP:    keys.up    <= pressed;
          KEY_DOWN:  keys.down  <= pressed;
          KEY_LEFT:  keys.left  <= pressed;
          KEY_RIGHT: keys.right <= pressed;
          KEY_CTRL:  keys.ctrl  <= pressed;
          KEY_ALT:   keys.alt   <= pressed;
          KEY_SHIFT: keys.shift <= pressed;
          KEY_SPACE: keys.space <= pressed;
          KEY_1:     keys.k1    <= pressed;
          KEY_2:     keys.k2    <= pressed;
          KEY_5:     keys.k5    <= pressed;
          KEY_6:     keys.k6    <= pressed;
          KEY_A:     keys.a     <= pressed;
          KEY_S:     keys.s     <= pressed;
          KEY_Q:     keys.q     <= pressed;
          KEY_R:     keys.r     <= pressed;
          KEY_F:     keys.f     <= pressed;
          KEY_D:     keys.d     <= pressed;
          KEY_G:     keys.g     <= pressed;
          KEY_P:     keys.p     <= pressed;
          KEY_W:     keys.w     <= pressed;
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Player merge
  //////////////////////////////////////////////////

  // Player 1 on arrows and left-hand modifiers
  always_comb begin
    player_1.up         = keys.up    | joystick_0[JOY_UP];
    player_1.down       = keys.down  | joystick_0[JOY_DOWN];
    player_1.left       = keys.left  | joystick_0[JOY_LEFT];
    player_1.right      = keys.right | joystick_0[JOY_RIGHT];
    player_1.buttons[0] = keys.ctrl  | joystick_0[JOY_BTN_LSB];
    player_1.buttons[1] = keys.alt   | joystick_0[JOY_BTN_LSB + 1];
    player_1.buttons[2] = keys.space | joystick_0[JOY_BTN_LSB + 2];
    player_1.buttons[3] = keys.shift | joystick_0[JOY_BTN_LSB + 3];
    player_1.start      = keys.k1    | joystick_0[JOY_START];
    player_1.coin       = keys.k5    | joystick_0[JOY_COIN];
    player_1.pause      = keys.p     | joystick_0[JOY_PAUSE];
  end

  // Player 2 on the RDFG cluster, no pause key
  always_comb begin
    player_2.up         = keys.r     | joystick_1[JOY_UP];
    player_2.down       = keys.f     | joystick_1[JOY_DOWN];
    player_2.left       = keys.d     | joystick_1[JOY_LEFT];
    player_2.right      = keys.g     | joystick_1[JOY_RIGHT];
    player_2.buttons[0] = keys.a     | joystick_1[JOY_BTN_LSB];
    player_2.buttons[1] = keys.s     | joystick_1[JOY_BTN_LSB + 1];
    player_2.buttons[2] = keys.q     | joystick_1[JOY_BTN_LSB + 2];
    player_2.buttons[3] = keys.w     | joystick_1[JOY_BTN_LSB + 3];
    player_2.start      = keys.k2    | joystick_1[JOY_START];
    player_2.coin       = keys.k6    | joystick_1[JOY_COIN];
    player_2.pause      = joystick_1[JOY_PAUSE];
  end

  // Host must present a known toggle once out of reset
  a_toggle_known : assert property (
    @(posedge clk_sys) disable iff (RESET)
    !$isunknown(ps2_key[PS2_TOGGLE])
  );

endmodule

// File: logic/option_decoder.sv
module option_decoder
  import cave_pkg::*;
(
  input  logic       clk_sys,
  input  logic       RESET,
  input  status_t    status,
  input  logic       forced_scandoubler,
  output video_opt_t video_opt,
  output core_opt_t  core_opt
);

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  logic [1:0] aspect;
  logic [2:0] fx;
  logic [2:0] fx_m1;
  logic       rotate;
  video_opt_t video_nxt;
  core_opt_t  core_nxt;

  assign aspect = status[ST_ASPECT_LSB +: 2];
  assign fx     = status[ST_FX_LSB +: 3];
  assign fx_m1  = fx - 3'd1;
  assign rotate = status[ST_ROTATE];

  //////////////////////////////////////////////////
  // Video options
  //////////////////////////////////////////////////

  always_comb begin
    // Original aspect, swapped for a rotated screen
    if (aspect == 2'd0) begin
      video_nxt.arx = rotate ? aspect_t'(3) : aspect_t'(4);
      video_nxt.ary = rotate ? aspect_t'(4) : aspect_t'(3);
    end else begin
      // Fullscreen and custom ratios, ary zero selects preset
      video_nxt.arx = aspect_t'(aspect) - aspect_t'(1);
      video_nxt.ary = '0;
    end
    // fx 0 none, 1 HQ2x, 2 to 4 CRT levels
    video_nxt.scanline    = (fx != 3'd0) ? fx_m1[1:0] : 2'd0;
    video_nxt.scandoubler = (fx != 3'd0) | forced_scandoubler;
    video_nxt.hq2x        = (fx == 3'd1);
  end

  //////////////////////////////////////////////////
  // Core options
  //////////////////////////////////////////////////

  always_comb begin
    core_nxt.offset_x      = status[ST_OFFX_LSB +: 4];
    core_nxt.offset_y      = status[ST_OFFY_LSB +: 4];
    core_nxt.rotate        = rotate;
    core_nxt.flip          = status[ST_FLIP];
    core_nxt.compatibility = status[ST_COMPAT];
    core_nxt.service       = status[ST_SERVICE];
    // Menu bits are disables, core wants enables
    core_nxt.layer_enable  = ~status[ST_LAYER_LSB +: 8];
    core_nxt.game_index    = status[ST_GAME_LSB +: 4];
  end

  // One cycle of latency on both structs
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      video_opt <= '0;
      core_opt  <= '0;
    end else begin
      video_opt <= video_nxt;
      core_opt  <= core_nxt;
    end
  end

  // HQ2x needs the doubler and no scanline overlay
  a_hq2x_doubled : assert property (
    @(posedge clk_sys) disable iff (RESET)
    video_opt.hq2x |-> (video_opt.scandoubler && video_opt.scanline == 2'd0)
  );

endmodule

// File: logic/cave_ctrl_top.sv
module cave_ctrl_top
  import cave_pkg::*;
#(
  parameter int PLL_RESET_CYCLES = PLL_RESET_CYCLES_DEFAULT,
  parameter int SYNC_STAGES      = 2
) (
  // Clock and reset
  input  logic       clk_sys,
  input  logic       RESET,
  input  logic       pll_locked,
  // Host side
  input  status_t    status,
  input  logic       user_reset,
  input  logic       forced_scandoubler,
  input  ps2_event_t ps2_key,
  input  joystick_t  joystick_0,
  input  joystick_t  joystick_1,
  // Generated resets
  output logic       rst_pll,
  output logic       rst_sys,
  output logic       rst_cpu,
  // Core side
  output player_t    player_1,
  output player_t    player_2,
  output video_opt_t video_opt,
  output core_opt_t  core_opt
);

  //////////////////////////////////////////////////
  // Resets
  //////////////////////////////////////////////////

  reset_sequencer #(
    .PLL_RESET_CYCLES (PLL_RESET_CYCLES),
    .SYNC_STAGES      (SYNC_STAGES)
  ) u_reset_sequencer (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .status     (status),
    .user_reset (user_reset),
    .rst_pll    (rst_pll),
    .rst_sys    (rst_sys),
    .rst_cpu    (rst_cpu)
  );

  //////////////////////////////////////////////////
  // Controls
  //////////////////////////////////////////////////

  // Cleared by RESET only, independent of generated resets
  control_decoder u_control_decoder (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .ps2_key    (ps2_key),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .player_1   (player_1),
    .player_2   (player_2)
  );

  //////////////////////////////////////////////////
  // Options
  //////////////////////////////////////////////////

  option_decoder u_option_decoder (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .video_opt          (video_opt),
    .core_opt           (core_opt)
  );

endmodule

// File: test/tb_cave_ctrl.sv
module tb_cave_ctrl
  import cave_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // One line of the vector file
  typedef struct packed {
    status_t    status;
    logic       forced_sd;
    joystick_t  joy_0;
    joystick_t  joy_1;
    ps2_event_t ps2;
    player_t    exp_p1;
    player_t    exp_p2;
    video_opt_t exp_video;
    core_opt_t  exp_core;
  } vector_t;

  localparam string VECTOR_FILE = "test/cave_ctrl_tests.txt";
  localparam int    PLL_HOLD    = 256;

  //////////////////////////////////////////////////
  // DUT and clock
  //////////////////////////////////////////////////

  logic       clk_sys = 1'b0;
  logic       RESET;
  logic       pll_locked;
  status_t    status;
  logic       user_reset;
  logic       forced_scandoubler;
  ps2_event_t ps2_key;
  joystick_t  joystick_0;
  joystick_t  joystick_1;
  logic       rst_pll;
  logic       rst_sys;
  logic       rst_cpu;
  player_t    player_1;
  player_t    player_2;
  video_opt_t video_opt;
  core_opt_t  core_opt;

  vector_t vectors[$];
  int      cycles      = 0;
  int      cycle_limit = 0;

  cave_ctrl_top #(
    .PLL_RESET_CYCLES (PLL_HOLD),
    .SYNC_STAGES      (2)
  ) DUT (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .pll_locked         (pll_locked),
    .status             (status),
    .user_reset         (user_reset),
    .forced_scandoubler (forced_scandoubler),
    .ps2_key            (ps2_key),
    .joystick_0         (joystick_0),
    .joystick_1         (joystick_1),
    .rst_pll            (rst_pll),
    .rst_sys            (rst_sys),
    .rst_cpu            (rst_cpu),
    .player_1           (player_1),
    .player_2           (player_2),
    .video_opt          (video_opt),
    .core_opt           (core_opt)
  );

  // 100 ns period
  always #50 clk_sys = ~clk_sys;

  // Run limit, armed once the vectors are counted
  always @(posedge clk_sys) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles", cycles));
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  // Inputs change here, outputs settled by now
  task automatic next_cycle();
    @(posedge clk_sys);
    #5;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("FAIL at %0d ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      abort_run($sformatf("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_status, f_fsd, f_joy0, f_joy1, f_ps2;
    logic [31:0] f_p1, f_p2, f_video, f_core;
    vector_t     v;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      abort_run({"Could not open the vector file ", VECTOR_FILE});
    end
    while ($fgets(line, fd) > 0) begin
      // Hash marks a column legend
      if (line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_status, f_fsd, f_joy0, f_joy1,
                  f_ps2, f_p1, f_p2, f_video, f_core);
      // Blank line
      if (n <= 0) begin
        continue;
      end
      if (n != 9) begin
        abort_run($sformatf("Vector %0d has %0d fields instead of 9", vectors.size() + 1, n));
      end
      v.status    = f_status;
      v.forced_sd = f_fsd[0];
      v.joy_0     = f_joy0;
      v.joy_1     = f_joy1;
      v.ps2       = f_ps2[10:0];
      v.exp_p1    = f_p1[10:0];
      v.exp_p2    = f_p2[10:0];
      v.exp_video = f_video[27:0];
      v.exp_core  = f_core[23:0];
      vectors.push_back(v);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // Test phases
  //////////////////////////////////////////////////

  task automatic check_reset_state();
    int waited;
    repeat (4) next_cycle();
    // Last reset cycle, all registers cleared
    check_value("player_1 in reset", 32'(player_1), 32'd0);
    check_value("player_2 in reset", 32'(player_2), 32'd0);
    check_value("video_opt in reset", 32'(video_opt), 32'd0);
    check_value("core_opt in reset", 32'(core_opt), 32'd0);
    check_bit("rst_pll in reset", rst_pll, 1'b0);
    check_bit("rst_sys in reset", rst_sys, 1'b1);
    check_bit("rst_cpu in reset", rst_cpu, 1'b1);
    RESET  = 1'b0;
    waited = 0;
    while (rst_sys && waited < 3) begin
      next_cycle();
      waited++;
    end
    check_bit("rst_sys after reset release", rst_sys, 1'b0);
    check_bit("rst_cpu after reset release", rst_cpu, 1'b0);
    check_bit("rst_pll after reset release", rst_pll, 1'b0);
  endtask

  // Drive one line, let keys and options settle two edges
  task automatic apply_vector(input int idx, input vector_t v);
    status             = v.status;
    forced_scandoubler = v.forced_sd;
    joystick_0         = v.joy_0;
    joystick_1         = v.joy_1;
    ps2_key            = v.ps2;
    next_cycle();
    next_cycle();
    check_value($sformatf("vector %0d player_1", idx), 32'(player_1), 32'(v.exp_p1));
    check_value($sformatf("vector %0d player_2", idx), 32'(player_2), 32'(v.exp_p2));
    check_value($sformatf("vector %0d video_opt", idx), 32'(video_opt), 32'(v.exp_video));
    check_value($sformatf("vector %0d core_opt", idx), 32'(core_opt), 32'(v.exp_core));
  endtask

  task automatic check_lock_loss();
    int high_cycles;
    next_cycle();
    pll_locked = 1'b0;
    // System reset is asynchronous to the loss
    #1;
    check_bit("rst_sys while unlocked", rst_sys, 1'b1);
    check_bit("rst_pll before lock-loss edge", rst_pll, 1'b0);
    next_cycle();
    check_bit("rst_pll after lock loss", rst_pll, 1'b1);
    check_bit("rst_sys while unlocked", rst_sys, 1'b1);
    high_cycles = 1;
    // One-cycle glitch only
    pll_locked  = 1'b1;
    while (rst_pll && high_cycles <= PLL_HOLD) begin
      next_cycle();
      if (rst_pll) begin
        high_cycles++;
      end
    end
    check_value("rst_pll high cycles", high_cycles, PLL_HOLD);
    check_bit("rst_sys after relock", rst_sys, 1'b0);
  endtask

  task automatic check_cpu_reset(input string cause, input logic from_status);
    next_cycle();
    if (from_status) begin
      status[ST_RESET] = 1'b1;
    end else begin
      user_reset = 1'b1;
    end
    #1;
    check_bit({"rst_cpu on ", cause}, rst_cpu, 1'b1);
    check_bit({"rst_sys on ", cause}, rst_sys, 1'b0);
    repeat (3) next_cycle();
    check_bit({"rst_cpu held by ", cause}, rst_cpu, 1'b1);
    check_bit({"rst_sys with ", cause}, rst_sys, 1'b0);
    status[ST_RESET] = 1'b0;
    user_reset       = 1'b0;
    // Two synchronizer stages to release
    next_cycle();
    check_bit({"rst_cpu one cycle after ", cause}, rst_cpu, 1'b1);
    next_cycle();
    check_bit({"rst_cpu two cycles after ", cause}, rst_cpu, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    RESET              = 1'b1;
    pll_locked         = 1'b1;
    status             = '0;
    user_reset         = 1'b0;
    forced_scandoubler = 1'b0;
    ps2_key            = '0;
    joystick_0         = '0;
    joystick_1         = '0;
    load_vectors();
    if (vectors.size() == 0) begin
      abort_run("The vector file holds no vectors");
    end
    cycle_limit = 4 * vectors.size() + 600;
    check_reset_state();
    foreach (vectors[i]) begin
      apply_vector(i + 1, vectors[i]);
    end
    check_lock_loss();
    check_cpu_reset("status bit 0", 1'b1);
    check_cpu_reset("user_reset", 1'b0);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: test/cave_ctrl_tests.txt
# Columns in hex: status forced_scandoubler joystick_0 joystick_1 ps2_key
# then expected player_1 player_2 video_opt core_opt; ps2_key bit 10 flips per key event
00000000 0 00000000 00000000 000 000 000 0040030 000ff0
0003fc00 0 00000000 00000000 000 000 000 0040030 000000
0003fc08 0 00000000 00000000 000 000 000 0030040 008000
0003fc04 0 00000000 00000000 000 000 000 0010000 000000
0003fc06 0 00000000 00000000 000 000 000 0020000 000000
0003fc02 0 00000000 00000000 000 000 000 0000000 000000
0003fc20 0 00000000 00000000 000 000 000 0040033 000000
0003fc40 0 00000000 00000000 000 000 000 0040036 000000
0003fc60 0 00000000 00000000 000 000 000 004003a 000000
0003fc80 0 00000000 00000000 000 000 000 004003e 000000
0003fc00 1 00000000 00000000 000 000 000 0040032 000000
5a255710 0 00000000 00000000 000 000 000 0040030 a57aa9
0003fc0c 0 00000000 00000000 000 000 000 0010000 008000
0003fc00 0 00000000 00000000 675 400 000 0040030 000000
0003fc00 0 00000000 00000000 214 408 000 0040030 000000
0003fc00 0 00000000 00000000 616 40c 000 0040030 000000
0003fc00 0 00000000 00000000 22e 40e 000 0040030 000000
0003fc00 0 00000000 00000000 475 00e 000 0040030 000000
0003fc00 0 00000000 00000000 22d 00e 400 0040030 000000
0003fc00 0 00000000 00000000 61c 00e 408 0040030 000000
0003fc00 0 00000000 00000000 21e 00e 40c 0040030 000000
0003fc00 0 00000000 00000000 636 00e 40e 0040030 000000
0003fc00 0 00000000 00000000 25a 00e 40e 0040030 000000
0003fc00 0 00000000 00000000 61d 00e 44e 0040030 000000
0003fc00 0 00000000 00000000 24d 00f 44e 0040030 000000
0003fc00 0 00000000 00000000 414 007 44e 0040030 000000
0003fc00 0 000000f0 00000400 414 07f 44f 0040030 000000
0003fc00 0 0000000f 00000001 414 787 4ce 0040030 000000
0003fc00 0 00000000 00000000 02d 007 04e 0040030 000000
0003fc00 0 00000000 00000000 416 003 04e 0040030 000000
0003fc00 0 00000000 00000000 02e 001 04e 0040030 000000
0003fc00 0 00000000 00000000 44d 000 04e 0040030 000000
0003fc00 0 00000000 00000000 01c 000 046 0040030 000000
0003fc00 0 00000000 00000000 41d 000 006 0040030 000000
0003fc00 0 00000000 00000000 01e 000 002 0040030 000000
0003fc00 0 00000000 00000400 01e 000 003 0040030 000000

// File: src.f
logic/cave_pkg.sv
logic/reset_sequencer.sv
logic/control_decoder.sv
logic/option_decoder.sv
logic/cave_ctrl_top.sv
test/tb_cave_ctrl.sv

// File: Makefile
# Verilator build and run of the cave control testbench
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_cave_ctrl
FILELIST  := src.f
PASS_MSG  := TEST RESULT: PASS

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
